//--- logic/mem_ctrl_pkg.sv
// Sizes, enums and packed structs shared by every block of the banked SRAM request controller
`default_nettype none

package mem_ctrl_pkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int N_CLIENTS   = 4;
	localparam int N_BANKS     = 4;
	localparam int LINE_BYTES  = 8;
	localparam int ADDR_W      = 8;
	localparam int LINE_W      = LINE_BYTES * 8;
	localparam int BANK_DEPTH  = 8;
	localparam int QUEUE_DEPTH = 2;

	// Byte address is offset, then bank, then line index from the low end
	localparam int OFF_W    = $clog2(LINE_BYTES);
	localparam int BANK_W   = $clog2(N_BANKS);
	localparam int INDEX_W  = $clog2(BANK_DEPTH);
	localparam int IDX_LSB  = OFF_W + BANK_W;
	localparam int SIZE_W   = $clog2(LINE_BYTES) + 1;
	localparam int CLIENT_W = $clog2(N_CLIENTS);
	localparam int QPTR_W   = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W   = $clog2(QUEUE_DEPTH + 1);

	// ------------------------------
	// Enums
	// ------------------------------
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} opcode_t;

	typedef enum logic [1:0] {
		ENG_IDLE = 2'd0,
		ENG_WAIT = 2'd1,
		ENG_RESP = 2'd2
	} engine_state_t;

	// ------------------------------
	// Structs
	// ------------------------------
	// Client request, first byte of wdata in the low byte
	typedef struct packed {
		opcode_t                 op;
		logic [ADDR_W-1:0]       addr;
		logic [SIZE_W-1:0]       size;
		logic [LINE_W-1:0]       wdata;
	} mem_req_t;

	// Client response, bytes beyond the size read as zero
	typedef struct packed {
		opcode_t                 op;
		logic [LINE_W-1:0]       data;
	} mem_rsp_t;

	// One engine's line request to one bank
	typedef struct packed {
		logic                    req;
		logic                    wr;
		logic [INDEX_W-1:0]      index;
		logic [LINE_W-1:0]       wdata;
		logic [LINE_BYTES-1:0]   be;
	} bank_req_t;

endpackage

`default_nettype wire

//--- logic/client_intake.sv
// Per-client request queues that accept credited requests and hand the head to each engine
`timescale 1ns/100ps
`default_nettype none

module client_intake (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  logic [mem_ctrl_pkg::N_CLIENTS-1:0]                 req_valid,
	input  mem_ctrl_pkg::mem_req_t [mem_ctrl_pkg::N_CLIENTS-1:0] req,
	input  logic [mem_ctrl_pkg::N_CLIENTS-1:0]                 take,
	output logic [mem_ctrl_pkg::N_CLIENTS-1:0]                 head_valid,
	output mem_ctrl_pkg::mem_req_t [mem_ctrl_pkg::N_CLIENTS-1:0] head,
	output logic [mem_ctrl_pkg::N_CLIENTS-1:0]                 credit_return
);

	// Circular pointer step over QUEUE_DEPTH slots
	function automatic logic [mem_ctrl_pkg::QPTR_W-1:0] next_ptr(
		input logic [mem_ctrl_pkg::QPTR_W-1:0] p
	);
		logic [mem_ctrl_pkg::QPTR_W-1:0] n;
		if (int'(p) == mem_ctrl_pkg::QUEUE_DEPTH - 1)
			n = '0;
		else
			n = p + 1'b1;
		return n;
	endfunction

	for (genvar c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++) begin : g_queue
		mem_ctrl_pkg::mem_req_t slots [mem_ctrl_pkg::QUEUE_DEPTH];
		logic [mem_ctrl_pkg::QPTR_W-1:0] wr_ptr;
		logic [mem_ctrl_pkg::QPTR_W-1:0] rd_ptr;
		logic [mem_ctrl_pkg::QCNT_W-1:0] count;
		logic                            pop;

		// ------------------------------
		// Head and credit
		// ------------------------------
		assign head_valid[c] = (count != '0);
		assign head[c] = slots[rd_ptr];

		// Engine only takes a valid head, one credit goes back per pop
		assign pop = take[c] && head_valid[c];
		assign credit_return[c] = pop;

		// ------------------------------
		// Pointers and count
		// ------------------------------
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end else begin
				if (req_valid[c])
					wr_ptr <= next_ptr(wr_ptr);
				if (pop)
					rd_ptr <= next_ptr(rd_ptr);
				case ({req_valid[c], pop})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end

		// Credit guarantees a free slot whenever req_valid is high
		always_ff @(posedge clk) begin
			if (req_valid[c])
				slots[wr_ptr] <= req[c];
		end
	end

endmodule

`default_nettype wire

//--- logic/split_engine.sv
// Per-client engine that splits one access over one or two banks, aligns it and builds the response
`timescale 1ns/100ps
`default_nettype none

module split_engine (
	input  logic                                                       clk,
	input  logic                                                       rst_n,
	input  logic                                                       head_valid,
	input  mem_ctrl_pkg::mem_req_t                                     head,
	input  logic [mem_ctrl_pkg::N_BANKS-1:0]                           gnt,
	input  logic [mem_ctrl_pkg::N_BANKS-1:0][mem_ctrl_pkg::LINE_W-1:0] rdata,
	output logic                                                       take,
	output mem_ctrl_pkg::bank_req_t [mem_ctrl_pkg::N_BANKS-1:0]        bank_req,
	output logic                                                       rsp_valid,
	output mem_ctrl_pkg::mem_rsp_t                                     rsp
);

	// Wide enough for offset plus size without overflow
	typedef logic [mem_ctrl_pkg::SIZE_W:0] span_t;

	mem_ctrl_pkg::engine_state_t state;
	mem_ctrl_pkg::mem_req_t      cur_req;

	logic [mem_ctrl_pkg::OFF_W-1:0]        off;
	logic [mem_ctrl_pkg::BANK_W-1:0]       bank0;
	logic [mem_ctrl_pkg::BANK_W-1:0]       bank1;
	logic [mem_ctrl_pkg::INDEX_W-1:0]      idx0;
	logic [mem_ctrl_pkg::INDEX_W-1:0]      idx1;
	logic                                  is_read;
	logic                                  head_split;
	logic                                  pend0;
	logic                                  pend1;
	logic                                  grab0;
	logic                                  grab1;
	logic                                  gnt0;
	logic                                  gnt1;
	logic [mem_ctrl_pkg::LINE_BYTES-1:0]   size_mask;
	logic [2*mem_ctrl_pkg::LINE_BYTES-1:0] be_wide;
	logic [2*mem_ctrl_pkg::LINE_W-1:0]     wdata_wide;
	logic [mem_ctrl_pkg::LINE_W-1:0]       line0;
	logic [mem_ctrl_pkg::LINE_W-1:0]       line1;
	logic [2*mem_ctrl_pkg::LINE_W-1:0]     merged;

	// ------------------------------
	// Address decode
	// ------------------------------
	assign off     = cur_req.addr[mem_ctrl_pkg::OFF_W-1:0];
	assign bank0   = cur_req.addr[mem_ctrl_pkg::OFF_W +: mem_ctrl_pkg::BANK_W];
	assign idx0    = cur_req.addr[mem_ctrl_pkg::IDX_LSB +: mem_ctrl_pkg::INDEX_W];
	assign is_read = (cur_req.op == mem_ctrl_pkg::OP_READ);

	// Lines interleave over banks, so the second line sits in the next bank
	assign bank1 = bank0 + 1'b1;
	// Wrapping from the last bank moves to the next line row
	assign idx1  = (&bank0) ? idx0 + 1'b1 : idx0;

	assign head_split = (span_t'(head.addr[mem_ctrl_pkg::OFF_W-1:0]) + span_t'(head.size))
		> span_t'(mem_ctrl_pkg::LINE_BYTES);

	assign take = (state == mem_ctrl_pkg::ENG_IDLE) && head_valid;

	// ------------------------------
	// Write alignment
	// ------------------------------
	always_comb begin
		for (int j = 0; j < mem_ctrl_pkg::LINE_BYTES; j++)
			size_mask[j] = (j < int'(cur_req.size));
	end

	// Low half lands in the first line, high half in the second
	assign be_wide    = {{mem_ctrl_pkg::LINE_BYTES{1'b0}}, size_mask} << off;
	assign wdata_wide = {{mem_ctrl_pkg::LINE_W{1'b0}}, cur_req.wdata} << {off, 3'b000};

	always_comb begin
		bank_req = '0;
		for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin
			if (b == int'(bank0)) begin
				bank_req[b].req   = pend0;
				bank_req[b].wr    = !is_read;
				bank_req[b].index = idx0;
				bank_req[b].wdata = wdata_wide[mem_ctrl_pkg::LINE_W-1:0];
				bank_req[b].be    = be_wide[mem_ctrl_pkg::LINE_BYTES-1:0];
			end else if (b == int'(bank1)) begin
				bank_req[b].req   = pend1;
				bank_req[b].wr    = !is_read;
				bank_req[b].index = idx1;
				bank_req[b].wdata = wdata_wide[2*mem_ctrl_pkg::LINE_W-1:mem_ctrl_pkg::LINE_W];
				bank_req[b].be    = be_wide[2*mem_ctrl_pkg::LINE_BYTES-1:mem_ctrl_pkg::LINE_BYTES];
			end
		end
	end

	assign gnt0 = pend0 && gnt[bank0];
	assign gnt1 = pend1 && gnt[bank1];

	// ------------------------------
	// FSM
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_ctrl_pkg::ENG_IDLE;
			pend0 <= 1'b0;
			pend1 <= 1'b0;
			grab0 <= 1'b0;
			grab1 <= 1'b0;
		end else begin
			// Bank read data shows up one cycle after its grant
			grab0 <= gnt0 && is_read;
			grab1 <= gnt1 && is_read;
			case (state)
				mem_ctrl_pkg::ENG_IDLE: begin
					if (take) begin
						state <= mem_ctrl_pkg::ENG_WAIT;
						pend0 <= 1'b1;
						pend1 <= head_split;
					end
				end
				mem_ctrl_pkg::ENG_WAIT: begin
					if (gnt0)
						pend0 <= 1'b0;
					if (gnt1)
						pend1 <= 1'b0;
					// Last grant was one cycle back, its data is captured on this edge
					if (!pend0 && !pend1)
						state <= mem_ctrl_pkg::ENG_RESP;
				end
				mem_ctrl_pkg::ENG_RESP: state <= mem_ctrl_pkg::ENG_IDLE;
				default:                state <= mem_ctrl_pkg::ENG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			cur_req <= head;
		if (grab0)
			line0 <= rdata[bank0];
		if (grab1)
			line1 <= rdata[bank1];
	end

	// ------------------------------
	// Response
	// ------------------------------
	assign merged = {line1, line0} >> {off, 3'b000};

	always_comb begin
		rsp.op   = cur_req.op;
		rsp.data = '0;
		if (is_read) begin
			for (int j = 0; j < mem_ctrl_pkg::LINE_BYTES; j++) begin
				if (size_mask[j])
					rsp.data[j*8 +: 8] = merged[j*8 +: 8];
			end
		end
	end

	assign rsp_valid = (state == mem_ctrl_pkg::ENG_RESP);

endmodule

`default_nettype wire

//--- logic/bank_array.sv
// Round-robin arbitration per bank in front of byte-enabled line storage with registered read data
`timescale 1ns/100ps
`default_nettype none

module bank_array (
	input  logic                                                       clk,
	input  logic                                                       rst_n,
	input  mem_ctrl_pkg::bank_req_t [mem_ctrl_pkg::N_CLIENTS-1:0][mem_ctrl_pkg::N_BANKS-1:0]
		bank_req,
	output logic [mem_ctrl_pkg::N_CLIENTS-1:0][mem_ctrl_pkg::N_BANKS-1:0] gnt,
	output logic [mem_ctrl_pkg::N_BANKS-1:0][mem_ctrl_pkg::LINE_W-1:0]    rdata
);

	logic [mem_ctrl_pkg::N_BANKS-1:0][mem_ctrl_pkg::CLIENT_W-1:0] rr_ptr;
	logic [mem_ctrl_pkg::N_BANKS-1:0][mem_ctrl_pkg::CLIENT_W-1:0] win;
	logic [mem_ctrl_pkg::N_BANKS-1:0]                             hit;
	mem_ctrl_pkg::bank_req_t [mem_ctrl_pkg::N_BANKS-1:0]          sel;

	logic [mem_ctrl_pkg::LINE_W-1:0] mem [mem_ctrl_pkg::N_BANKS][mem_ctrl_pkg::BANK_DEPTH];

	// ------------------------------
	// Arbitration
	// ------------------------------
	// Search starts at the pointer, first requester wins
	always_comb begin
		logic [mem_ctrl_pkg::CLIENT_W-1:0] c;
		gnt = '0;
		win = '0;
		hit = '0;
		for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin
			for (int k = 0; k < mem_ctrl_pkg::N_CLIENTS; k++) begin
				c = rr_ptr[b] + k[mem_ctrl_pkg::CLIENT_W-1:0];
				if (!hit[b] && bank_req[c][b].req) begin
					gnt[c][b] = 1'b1;
					win[b]    = c;
					hit[b]    = 1'b1;
				end
			end
			sel[b] = bank_req[win[b]][b];
		end
	end

	// Pointer moves to the engine after the winner
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr <= '0;
		end else begin
			for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin
				if (hit[b])
					rr_ptr[b] <= win[b] + 1'b1;
			end
		end
	end

	// ------------------------------
	// Storage
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin
				for (int i = 0; i < mem_ctrl_pkg::BANK_DEPTH; i++)
					mem[b][i] <= '0;
			end
		end else begin
			for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin
				if (hit[b] && sel[b].wr) begin
					for (int j = 0; j < mem_ctrl_pkg::LINE_BYTES; j++) begin
						if (sel[b].be[j])
							mem[b][sel[b].index][j*8 +: 8] <= sel[b].wdata[j*8 +: 8];
					end
				end
			end
		end
	end

	// Read line is on rdata the cycle after its grant
	always_ff @(posedge clk) begin
		for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin
			if (hit[b] && !sel[b].wr)
				rdata[b] <= mem[b][sel[b].index];
		end
	end

endmodule

`default_nettype wire

//--- logic/mem_ctrl_top.sv
// Top level of the banked SRAM request controller, joining intake, split engines and banks
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_top (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   req_valid,
	input  mem_ctrl_pkg::mem_req_t [mem_ctrl_pkg::N_CLIENTS-1:0] req,
	output logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   credit_return,
	output logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   rsp_valid,
	output mem_ctrl_pkg::mem_rsp_t [mem_ctrl_pkg::N_CLIENTS-1:0] rsp
);

	logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   head_valid;
	logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   take;
	mem_ctrl_pkg::mem_req_t [mem_ctrl_pkg::N_CLIENTS-1:0] head;
	mem_ctrl_pkg::bank_req_t [mem_ctrl_pkg::N_CLIENTS-1:0][mem_ctrl_pkg::N_BANKS-1:0] bank_req;
	logic [mem_ctrl_pkg::N_CLIENTS-1:0][mem_ctrl_pkg::N_BANKS-1:0]   gnt;
	logic [mem_ctrl_pkg::N_BANKS-1:0][mem_ctrl_pkg::LINE_W-1:0]      rdata;

	client_intake u_client_intake (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req           (req),
		.take          (take),
		.head_valid    (head_valid),
		.head          (head),
		.credit_return (credit_return)
	);

	// One engine per client
	for (genvar c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++) begin : g_engine
		split_engine u_split_engine (
			.clk        (clk),
			.rst_n      (rst_n),
			.head_valid (head_valid[c]),
			.head       (head[c]),
			.gnt        (gnt[c]),
			.rdata      (rdata),
			.take       (take[c]),
			.bank_req   (bank_req[c]),
			.rsp_valid  (rsp_valid[c]),
			.rsp        (rsp[c])
		);
	end

	bank_array u_bank_array (
		.clk      (clk),
		.rst_n    (rst_n),
		.bank_req (bank_req),
		.gnt      (gnt),
		.rdata    (rdata)
	);

endmodule

`default_nettype wire

//--- tests/mem_ctrl_assertions.sv
// Concurrent checks on credit use, bank grants and response pulses, bound onto the top level
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_assertions (
	input logic                                                                  clk,
	input logic                                                                  rst_n,
	input logic [mem_ctrl_pkg::N_CLIENTS-1:0]                                    req_valid,
	input logic [mem_ctrl_pkg::N_CLIENTS-1:0]                                    credit_return,
	input logic [mem_ctrl_pkg::N_CLIENTS-1:0]                                    rsp_valid,
	input logic [mem_ctrl_pkg::N_CLIENTS-1:0][mem_ctrl_pkg::N_BANKS-1:0]         gnt,
	input mem_ctrl_pkg::bank_req_t [mem_ctrl_pkg::N_CLIENTS-1:0][mem_ctrl_pkg::N_BANKS-1:0]
		bank_req
);

	// Number of assertion failures so far
	int fail_count = 0;

	// ------------------------------
	// Per-client rules
	// ------------------------------
	for (genvar c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++) begin : g_client
		logic [mem_ctrl_pkg::QCNT_W-1:0] credit_cnt;

		// Own credit count, independent of the testbench
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n)
				credit_cnt <= mem_ctrl_pkg::QCNT_W'(mem_ctrl_pkg::QUEUE_DEPTH);
			else
				credit_cnt <= credit_cnt - req_valid[c] + credit_return[c];
		end

		a_credit: assert property (@(posedge clk) disable iff (!rst_n)
			req_valid[c] |-> credit_cnt != '0)
			else begin
				$error("Client %0d raised req_valid with no credit", c);
				fail_count++;
			end

		a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
			rsp_valid[c] |=> !rsp_valid[c])
			else begin
				$error("Client %0d rsp_valid high two cycles in a row", c);
				fail_count++;
			end

		for (genvar b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin : g_bank
			a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
				gnt[c][b] |-> bank_req[c][b].req)
				else begin
					$error("Bank %0d granted engine %0d without a request", b, c);
					fail_count++;
				end
		end
	end

	// ------------------------------
	// Per-bank rules
	// ------------------------------
	for (genvar b = 0; b < mem_ctrl_pkg::N_BANKS; b++) begin : g_bank_gnt
		logic [mem_ctrl_pkg::N_CLIENTS-1:0] col;

		always_comb begin
			for (int c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++)
				col[c] = gnt[c][b];
		end

		a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(col))
			else begin
				$error("Bank %0d granted more than one engine", b);
				fail_count++;
			end
	end

endmodule

`default_nettype wire

//--- tests/mem_ctrl_tb.sv
// Directed testbench for the banked SRAM request controller, run as the simulation top
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_tb;

	// Roughly ten times the longest expected run
	localparam int TIMEOUT_CYCLES = 3000;

	logic                                                 clk;
	logic                                                 rst_n;
	logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   req_valid;
	mem_ctrl_pkg::mem_req_t [mem_ctrl_pkg::N_CLIENTS-1:0] req;
	logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   credit_return;
	logic [mem_ctrl_pkg::N_CLIENTS-1:0]                   rsp_valid;
	mem_ctrl_pkg::mem_rsp_t [mem_ctrl_pkg::N_CLIENTS-1:0] rsp;

	logic [7:0]             ref_mem [256];
	int                     credits [mem_ctrl_pkg::N_CLIENTS];
	mem_ctrl_pkg::mem_rsp_t exp_q [mem_ctrl_pkg::N_CLIENTS][$];
	int                     cycle_count = 0;
	int                     seed;

	mem_ctrl_top u_mem_ctrl_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req           (req),
		.credit_return (credit_return),
		.rsp_valid     (rsp_valid),
		.rsp           (rsp)
	);

	bind mem_ctrl_top mem_ctrl_assertions u_mem_ctrl_assertions (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.credit_return (credit_return),
		.rsp_valid     (rsp_valid),
		.gnt           (gnt),
		.bank_req      (bank_req)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	// Each byte derived from its own full address
	function automatic logic [63:0] fill_line(input logic [7:0] addr, input logic [7:0] key);
		logic [63:0] line;
		for (int j = 0; j < 8; j++)
			line[j*8 +: 8] = (addr + 8'(j)) ^ key;
		return line;
	endfunction

	// Waits for credit, records the expected response, then drives one cycle
	task automatic send_req(input int c, input mem_ctrl_pkg::opcode_t op,
		input logic [7:0] addr, input int size, input logic [63:0] wdata);
		mem_ctrl_pkg::mem_rsp_t exp;
		logic [7:0]             a;
		while (credits[c] == 0)
			@(negedge clk);
		exp.op   = op;
		exp.data = '0;
		for (int j = 0; j < size; j++) begin
			a = addr + 8'(j);
			if (op == mem_ctrl_pkg::OP_WRITE)
				ref_mem[a] = wdata[j*8 +: 8];
			else
				exp.data[j*8 +: 8] = ref_mem[a];
		end
		exp_q[c].push_back(exp);
		credits[c]--;
		req[c].op    = op;
		req[c].addr  = addr;
		req[c].size  = 4'(size);
		req[c].wdata = wdata;
		req_valid[c] = 1'b1;
		@(negedge clk);
		req_valid[c] = 1'b0;
	endtask

	// All responses back means every credit is home too
	task automatic wait_drain();
		bit busy;
		busy = 1'b1;
		while (busy) begin
			@(negedge clk);
			busy = 1'b0;
			for (int c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++) begin
				if (exp_q[c].size() != 0)
					busy = 1'b1;
			end
		end
		for (int c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++)
			check_value($sformatf("credits[%0d]", c), 64'(credits[c]),
				64'(mem_ctrl_pkg::QUEUE_DEPTH));
	endtask

	// ------------------------------
	// Monitor and timeout
	// ------------------------------
	always @(posedge clk) begin : monitor
		mem_ctrl_pkg::mem_rsp_t exp;
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("Timeout: the DUT did not finish the tests in time");
		end else if (u_mem_ctrl_top.u_mem_ctrl_assertions.fail_count != 0) begin
			abort_run("A concurrent assertion on the DUT failed");
		end else if (rst_n) begin
			for (int c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++) begin
				if (credit_return[c])
					credits[c]++;
				if (credits[c] > mem_ctrl_pkg::QUEUE_DEPTH) begin
					abort_run($sformatf("Client %0d got back more credits than it spent", c));
				end else if (rsp_valid[c] && exp_q[c].size() == 0) begin
					abort_run($sformatf("Client %0d got a response it never asked for", c));
				end else if (rsp_valid[c]) begin
					exp = exp_q[c].pop_front();
					check_value($sformatf("rsp[%0d].op", c), 64'(rsp[c].op), 64'(exp.op));
					check_value($sformatf("rsp[%0d].data", c), rsp[c].data, exp.data);
				end
			end
		end
	end

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_reset_credit();
		check_value("rsp_valid", 64'(rsp_valid), 64'd0);
		check_value("credit_return", 64'(credit_return), 64'd0);
		// Engine holds one and the queue fills, so the last one waits for a credit
		for (int c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++) begin
			for (int k = 0; k < mem_ctrl_pkg::QUEUE_DEPTH + 2; k++)
				send_req(c, mem_ctrl_pkg::OP_READ, 8'(c*8 + k), 1, '0);
		end
		wait_drain();
	endtask

	task automatic test_aligned_lines();
		for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++)
			send_req(0, mem_ctrl_pkg::OP_WRITE, 8'(b*8), 8, fill_line(8'(b*8), 8'h5a));
		for (int b = 0; b < mem_ctrl_pkg::N_BANKS; b++)
			send_req(0, mem_ctrl_pkg::OP_READ, 8'(b*8), 8, '0);
		wait_drain();
	endtask

	task automatic test_straddle();
		for (int k = 0; k < 4; k++)
			send_req(0, mem_ctrl_pkg::OP_WRITE, 8'(8'h38 + k*8), 8,
				fill_line(8'(8'h38 + k*8), 8'h5a));
		// Bank 3 into bank 0 of the next row
		send_req(0, mem_ctrl_pkg::OP_WRITE, 8'h3d, 6, fill_line(8'h3d, 8'hc3));
		// Bank 1 into bank 2
		send_req(0, mem_ctrl_pkg::OP_WRITE, 8'h4c, 8, fill_line(8'h4c, 8'hc3));
		for (int k = 0; k < 4; k++)
			send_req(0, mem_ctrl_pkg::OP_READ, 8'(8'h38 + k*8), 8, '0);
		send_req(0, mem_ctrl_pkg::OP_READ, 8'h3a, 8, '0);
		send_req(0, mem_ctrl_pkg::OP_READ, 8'h4b, 7, '0);
		wait_drain();
	endtask

	task automatic test_short_reads();
		send_req(1, mem_ctrl_pkg::OP_READ, 8'h09, 1, '0);
		send_req(1, mem_ctrl_pkg::OP_READ, 8'h13, 3, '0);
		send_req(1, mem_ctrl_pkg::OP_READ, 8'h1f, 2, '0);
		send_req(1, mem_ctrl_pkg::OP_READ, 8'h3f, 4, '0);
		wait_drain();
	endtask

	// Every client hits bank 2, each on its own line
	task automatic same_bank_traffic(input int c);
		logic [7:0] base;
		base = {3'(c + 4), 2'd2, 3'd0};
		send_req(c, mem_ctrl_pkg::OP_WRITE, base, 8, fill_line(base, 8'h96));
		send_req(c, mem_ctrl_pkg::OP_READ, base, 8, '0);
		send_req(c, mem_ctrl_pkg::OP_READ, base + 8'd3, 4, '0);
		send_req(c, mem_ctrl_pkg::OP_WRITE, base + 8'd1, 2, fill_line(base, 8'h0f));
		send_req(c, mem_ctrl_pkg::OP_READ, base, 8, '0);
	endtask

	// Client c stays inside bytes c*64 to c*64+63, with its own random sequence
	task automatic random_traffic(input int c, input int n);
		mem_ctrl_pkg::opcode_t op;
		logic [7:0]            addr;
		int                    size;
		int                    lseed;
		lseed = seed ^ c;
		for (int k = 0; k < n; k++) begin
			op   = ($random(lseed) & 1) ? mem_ctrl_pkg::OP_WRITE : mem_ctrl_pkg::OP_READ;
			addr = 8'(c*64 + $unsigned($random(lseed)) % 57);
			size = 1 + $unsigned($random(lseed)) % 8;
			send_req(c, op, addr, size, {$random(lseed), $random(lseed)});
		end
	endtask

	initial begin
		seed      = 32'hd52d_97f8;
		rst_n     = 1'b0;
		req_valid = '0;
		req       = '0;
		for (int c = 0; c < mem_ctrl_pkg::N_CLIENTS; c++)
			credits[c] = mem_ctrl_pkg::QUEUE_DEPTH;
		for (int a = 0; a < 256; a++)
			ref_mem[a] = 8'h00;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_reset_credit();
		test_aligned_lines();
		test_straddle();
		test_short_reads();
		fork
			same_bank_traffic(0);
			same_bank_traffic(1);
			same_bank_traffic(2);
			same_bank_traffic(3);
		join
		wait_drain();
		fork
			random_traffic(0, 24);
			random_traffic(1, 24);
			random_traffic(2, 24);
			random_traffic(3, 24);
		join
		wait_drain();

		if (u_mem_ctrl_top.u_mem_ctrl_assertions.fail_count != 0) begin
			abort_run("A concurrent assertion on the DUT failed");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- mem_ctrl.f
logic/mem_ctrl_pkg.sv
logic/client_intake.sv
logic/split_engine.sv
logic/bank_array.sv
logic/mem_ctrl_top.sv
tests/mem_ctrl_assertions.sv
tests/mem_ctrl_tb.sv
